//--- common/boot_pkg.sv
`default_nettype none

package boot_pkg;

  // ICCM word address width, fixed by the mem_wr_t layout
  localparam int ICCM_AW = 12;

  // reserved word that closes a UART load
  localparam logic [31:0] BOOT_END_WORD = 32'h0000_0FFF;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic {
    ST_LOAD,
    ST_RUN
  } boot_state_e;

  // master to slave
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // one ICCM write, word addressed with byte strobes
  typedef struct packed {
    logic               en;
    logic [ICCM_AW-1:0] addr;
    logic [31:0]        data;
    logic [3:0]         strb;
  } mem_wr_t;

endpackage

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 87
) (
  input  wire logic       clock,
  input  wire logic       rst_i,
  input  wire logic       rx_i,
  output logic            rx_valid_o,
  output logic [7:0]      rx_byte_o
);

  localparam int HALF_BIT = CLKS_PER_BIT / 2;
  localparam int CNT_W    = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e        state_q;
  logic [1:0]       sync_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             valid_q;
  logic             rx_s;
  logic             bit_end;

  assign rx_s    = sync_q[1];
  assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  // line idles high
  always_ff @(posedge clock) begin
    if (rst_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (!rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (cnt_q == CNT_W'(HALF_BIT - 1)) begin
            cnt_q <= '0;
            // still low at mid start bit, else it was a glitch
            state_q <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            // a low stop bit drops the byte
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clock) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

`default_nettype wire

//--- source/boot_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module boot_ctrl #(
  parameter int ICCM_WORDS = 1024
) (
  input  wire logic         clock,
  input  wire logic         rst_i,
  input  wire logic         rx_valid_i,
  input  wire logic [7:0]   rx_byte_i,
  output boot_pkg::mem_wr_t ldr_wr_o,
  output logic              loading_o,
  output logic              core_rst_o
);

  import boot_pkg::*;

  localparam logic [ICCM_AW-1:0] LAST_ADDR = ICCM_AW'(ICCM_WORDS - 1);

  boot_state_e        state_q;
  logic [1:0]         byte_cnt_q;
  logic [31:0]        word_q;
  logic [31:0]        word_next;
  logic [ICCM_AW-1:0] addr_q;
  logic               full_q;
  logic               wr_en_q;
  logic               byte_in;
  logic               word_done;

  assign byte_in   = rx_valid_i && (state_q == ST_LOAD);
  assign word_done = byte_in && (byte_cnt_q == 2'd3);

  // little endian: bytes enter at the top and move down,
  // so the first byte ends up in bits 7:0
  assign word_next = {rx_byte_i, word_q[31:8]};

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q    <= ST_LOAD;
      byte_cnt_q <= '0;
      addr_q     <= '0;
      full_q     <= 1'b0;
      wr_en_q    <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      if (byte_in) begin
        byte_cnt_q <= byte_cnt_q + 2'd1;
      end
      if (word_done) begin
        if (word_next == BOOT_END_WORD) begin
          state_q <= ST_RUN;
        end else begin
          wr_en_q <= !full_q;
        end
      end
      // address moves on once the write has gone out
      if (wr_en_q) begin
        if (addr_q == LAST_ADDR) begin
          full_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (byte_in) begin
      word_q <= word_next;
    end
  end

  always_comb begin
    ldr_wr_o.en   = wr_en_q;
    ldr_wr_o.addr = addr_q;
    ldr_wr_o.data = word_q;
    ldr_wr_o.strb = 4'hF;
  end

  // core stays in reset for the whole load
  assign loading_o  = (state_q == ST_LOAD);
  assign core_rst_o = (state_q == ST_LOAD);

endmodule

`default_nettype wire

//--- iccm/iccm_ram.sv
`timescale 1ns/1ns
`default_nettype none

module iccm_ram #(
  parameter int ICCM_WORDS = 1024
) (
  input  wire logic                         clock,
  input  wire boot_pkg::mem_wr_t            ldr_wr_i,
  input  wire boot_pkg::mem_wr_t            bus_wr_i,
  input  wire logic [boot_pkg::ICCM_AW-1:0] rd_addr_i,
  output logic [31:0]                       rd_data_o
);

  import boot_pkg::*;

  localparam int RAM_AW = $clog2(ICCM_WORDS);

  logic [31:0] mem_q [ICCM_WORDS];
  mem_wr_t     wr;

  // loader wins over the bus
  assign wr = ldr_wr_i.en ? ldr_wr_i : bus_wr_i;

  always_ff @(posedge clock) begin
    if (wr.en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr.strb[b]) begin
          mem_q[wr.addr[RAM_AW-1:0]][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
    rd_data_o <= mem_q[rd_addr_i[RAM_AW-1:0]];
  end

endmodule

`default_nettype wire

//--- iccm/iccm_axil_slave.sv
`timescale 1ns/1ns
`default_nettype none

module iccm_axil_slave #(
  parameter int ICCM_WORDS = 1024
) (
  input  wire logic                         clock,
  input  wire logic                         rst_i,
  input  wire boot_pkg::axil_req_t          axil_i,
  output boot_pkg::axil_rsp_t               axil_o,
  input  wire logic                         loading_i,
  output boot_pkg::mem_wr_t                 bus_wr_o,
  output logic [boot_pkg::ICCM_AW-1:0]      rd_addr_o,
  input  wire logic [31:0]                  rd_data_i
);

  import boot_pkg::*;

  logic               bvalid_q;
  logic               rvalid_q;
  axil_resp_e         bresp_q;
  axil_resp_e         rresp_q;
  logic [ICCM_AW-1:0] rd_addr_q;
  logic               idle;
  logic               rd_accept;
  logic               wr_accept;

  // byte address to ICCM word index
  function automatic logic [ICCM_AW-1:0] word_addr(input logic [31:0] byte_addr);
    return ICCM_AW'(byte_addr[13:2] % ICCM_WORDS);
  endfunction

  // one transaction at a time
  assign idle      = !bvalid_q && !rvalid_q;
  assign rd_accept = idle && axil_i.arvalid;
  // read goes first when both show up
  assign wr_accept = idle && !axil_i.arvalid && axil_i.awvalid && axil_i.wvalid;

  // hold the read address so rdata stays put under back-pressure
  assign rd_addr_o = rd_accept ? word_addr(axil_i.araddr) : rd_addr_q;

  always_comb begin
    bus_wr_o.en   = wr_accept && !loading_i;
    bus_wr_o.addr = word_addr(axil_i.awaddr);
    bus_wr_o.data = axil_i.wdata;
    bus_wr_o.strb = axil_i.wstrb;
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (axil_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // bus locked out while the UART load runs
  always_ff @(posedge clock) begin
    if (wr_accept) begin
      bresp_q <= loading_i ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_accept) begin
      rresp_q   <= loading_i ? RESP_SLVERR : RESP_OKAY;
      rd_addr_q <= word_addr(axil_i.araddr);
    end
  end

  always_comb begin
    axil_o.awready = wr_accept;
    axil_o.wready  = wr_accept;
    axil_o.bvalid  = bvalid_q;
    axil_o.bresp   = bresp_q;
    axil_o.arready = rd_accept;
    axil_o.rvalid  = rvalid_q;
    axil_o.rresp   = rresp_q;
    axil_o.rdata   = (rresp_q == RESP_SLVERR) ? 32'h0 : rd_data_i;
  end

endmodule

`default_nettype wire

//--- source/boot_top.sv
`timescale 1ns/1ns
`default_nettype none

module boot_top #(
  parameter int CLKS_PER_BIT = 87,
  parameter int ICCM_WORDS   = 1024
) (
  input  wire logic                clock,
  input  wire logic                rst_i,
  input  wire logic                uart_rx_i,
  input  wire boot_pkg::axil_req_t axil_i,
  output boot_pkg::axil_rsp_t      axil_o,
  output logic                     core_rst_o
);

  import boot_pkg::*;

  logic               rx_valid;
  logic [7:0]         rx_byte;
  mem_wr_t            ldr_wr;
  mem_wr_t            bus_wr;
  logic               loading;
  logic [ICCM_AW-1:0] rd_addr;
  logic [31:0]        rd_data;

  // boot path: serial bytes into the controller
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clock      (clock),
    .rst_i      (rst_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  boot_ctrl #(
    .ICCM_WORDS (ICCM_WORDS)
  ) u_boot_ctrl (
    .clock      (clock),
    .rst_i      (rst_i),
    .rx_valid_i (rx_valid),
    .rx_byte_i  (rx_byte),
    .ldr_wr_o   (ldr_wr),
    .loading_o  (loading),
    .core_rst_o (core_rst_o)
  );

  // bus side of the ICCM
  iccm_axil_slave #(
    .ICCM_WORDS (ICCM_WORDS)
  ) u_iccm_axil (
    .clock     (clock),
    .rst_i     (rst_i),
    .axil_i    (axil_i),
    .axil_o    (axil_o),
    .loading_i (loading),
    .bus_wr_o  (bus_wr),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data)
  );

  iccm_ram #(
    .ICCM_WORDS (ICCM_WORDS)
  ) u_iccm (
    .clock     (clock),
    .ldr_wr_i  (ldr_wr),
    .bus_wr_i  (bus_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

`default_nettype wire

//--- verif/boot_tb.sv
`timescale 1ns/1ns
`default_nettype none

module boot_tb;

  import boot_pkg::*;

  localparam int          CLKS_PER_BIT = 8;
  localparam int          ICCM_WORDS   = 1024;
  localparam int          N_WORDS      = 8;
  localparam int          M_WORDS      = 4;
  localparam int          BAD_IDX      = 6;
  localparam int          LOCK_ADDR    = 20;
  localparam logic [31:0] LOCK_DATA    = 32'hDEAD_BEEF;
  // all uart bytes of the run, one spare bit per frame
  localparam int          TOTAL_BYTES  = (N_WORDS + 1) * 4 + 4 + (M_WORDS + 1) * 4 + 1;
  localparam int          TIMEOUT_NS   = TOTAL_BYTES * 11 * CLKS_PER_BIT * 20 + 40000;

  logic        clock;
  logic        rst_i;
  logic        uart_rx;
  axil_req_t   req;
  axil_rsp_t   rsp;
  logic        core_rst;
  integer      seed;
  int          errors;
  int          checks;
  logic [31:0] exp_mem [N_WORDS];
  logic [31:0] rdata;

  boot_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .ICCM_WORDS   (ICCM_WORDS)
  ) i_dut (
    .clock      (clock),
    .rst_i      (rst_i),
    .uart_rx_i  (uart_rx),
    .axil_i     (req),
    .axil_o     (rsp),
    .core_rst_o (core_rst)
  );

  always #10 clock = ~clock;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $random(seed);
    // the end word would close the load early
    if (w == BOOT_END_WORD) begin
      w = w ^ 32'h1;
    end
    return w;
  endfunction

  task automatic apply_reset();
    @(posedge clock);
    rst_i <= 1'b1;
    repeat (5) @(posedge clock);
    rst_i <= 1'b0;
  endtask

  task automatic drive_bit(input logic v);
    @(posedge clock);
    uart_rx <= v;
    repeat (CLKS_PER_BIT - 1) @(posedge clock);
  endtask

  // 8N1 frame, lsb first
  task automatic uart_send_byte(input logic [7:0] b, input logic stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(stop);
    // line back to idle before the next start bit
    if (!stop) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int b = 0; b < 4; b++) begin
      uart_send_byte(w[8*b +: 8], 1'b1);
    end
  endtask

  task automatic wait_core_release();
    do begin
      @(negedge clock);
    end while (core_rst);
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clock);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    req.rready  <= 1'b1;
    do begin
      @(negedge clock);
    end while (!rsp.arready);
    @(posedge clock);
    req.arvalid <= 1'b0;
    do begin
      @(negedge clock);
    end while (!rsp.rvalid);
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clock);
    req.rready <= 1'b0;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    @(posedge clock);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    req.wstrb   <= strb;
    req.bready  <= 1'b1;
    do begin
      @(negedge clock);
    end while (!rsp.awready);
    // both write channels are taken on the same cycle
    check("axil_wready", 1, rsp.wready);
    @(posedge clock);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    do begin
      @(negedge clock);
    end while (!rsp.bvalid);
    resp = rsp.bresp;
    @(posedge clock);
    req.bready <= 1'b0;
  endtask

  task automatic test_reset_lockout();
    logic [1:0] resp;
    @(negedge clock);
    check("reset_core_rst", 1, core_rst);
    axil_read(32'(3 * 4), rdata, resp);
    check("lock_rresp", RESP_SLVERR, resp);
    check("lock_rdata", 0, rdata);
    axil_write(32'(LOCK_ADDR * 4), LOCK_DATA, 4'hF, resp);
    check("lock_bresp", RESP_SLVERR, resp);
  endtask

  task automatic test_load_and_read();
    logic [1:0] resp;
    for (int k = 0; k < N_WORDS; k++) begin
      exp_mem[k] = random_word();
      send_word(exp_mem[k]);
    end
    // core held in reset until the end word
    check("load_core_rst", 1, core_rst);
    send_word(BOOT_END_WORD);
    wait_core_release();
    for (int k = 0; k < N_WORDS; k++) begin
      axil_read(32'(k * 4), rdata, resp);
      check($sformatf("load_rresp_%0d", k), RESP_OKAY, resp);
      check($sformatf("load_word_%0d", k), exp_mem[k], rdata);
    end
    // write refused during the load left nothing behind
    axil_read(32'(LOCK_ADDR * 4), rdata, resp);
    check("lock_write_effect", 0, 32'(rdata === LOCK_DATA));
  endtask

  task automatic test_strobe_merge();
    logic [31:0] wval;
    logic [31:0] merged;
    logic [1:0]  resp;
    wval   = random_word();
    merged = (exp_mem[3] & 32'hFF00_FF00) | (wval & 32'h00FF_00FF);
    axil_write(32'(3 * 4), wval, 4'b0101, resp);
    check("strobe_bresp", RESP_OKAY, resp);
    axil_read(32'(3 * 4), rdata, resp);
    check("strobe_merge", merged, rdata);
    exp_mem[3] = merged;
  endtask

  task automatic test_read_backpressure();
    logic [31:0] held;
    logic [1:0]  resp;
    @(posedge clock);
    req.arvalid <= 1'b1;
    req.araddr  <= 32'(2 * 4);
    req.rready  <= 1'b0;
    do begin
      @(negedge clock);
    end while (!rsp.arready);
    @(posedge clock);
    req.arvalid <= 1'b0;
    do begin
      @(negedge clock);
    end while (!rsp.rvalid);
    held = rsp.rdata;
    check("bp_first_data", exp_mem[2], held);
    repeat (6) begin
      @(negedge clock);
      check("bp_rvalid_held", 1, rsp.rvalid);
      check("bp_rdata_held", held, rsp.rdata);
    end
    @(posedge clock);
    req.rready <= 1'b1;
    @(posedge clock);
    req.rready <= 1'b0;
    @(negedge clock);
    check("bp_rvalid_done", 0, rsp.rvalid);
    axil_read(32'(5 * 4), rdata, resp);
    check("bp_second_rresp", RESP_OKAY, resp);
    check("bp_second_data", exp_mem[5], rdata);
  endtask

  task automatic test_after_end_word();
    logic [31:0] extra;
    logic [1:0]  resp;
    extra = 32'h1234_5678;
    send_word(extra);
    repeat (4) @(negedge clock);
    check("after_end_core_rst", 0, core_rst);
    axil_read(32'(N_WORDS * 4), rdata, resp);
    check("after_end_next_addr", 0, 32'(rdata === extra));
    axil_read(32'(0), rdata, resp);
    check("after_end_word_0", exp_mem[0], rdata);
  endtask

  task automatic test_bad_stop_bit();
    logic [7:0]  bytes_q [$];
    logic [7:0]  pad;
    logic [31:0] w;
    logic [31:0] exp_w;
    logic [1:0]  resp;
    apply_reset();
    @(negedge clock);
    check("reload_core_rst", 1, core_rst);
    for (int k = 0; k < M_WORDS; k++) begin
      w = random_word();
      for (int b = 0; b < 4; b++) begin
        bytes_q.push_back(w[8*b +: 8]);
      end
    end
    for (int i = 0; i < bytes_q.size(); i++) begin
      uart_send_byte(bytes_q[i], i != BAD_IDX);
    end
    // one more byte so the end word lands on a word boundary
    w   = random_word();
    pad = w[7:0];
    uart_send_byte(pad, 1'b1);
    send_word(BOOT_END_WORD);
    wait_core_release();
    // dropped byte leaves a gap, the later bytes move down one place
    bytes_q.delete(BAD_IDX);
    bytes_q.push_back(pad);
    for (int k = 0; k < M_WORDS; k++) begin
      exp_w = {bytes_q[4*k+3], bytes_q[4*k+2], bytes_q[4*k+1], bytes_q[4*k]};
      axil_read(32'(k * 4), rdata, resp);
      check($sformatf("bad_stop_rresp_%0d", k), RESP_OKAY, resp);
      check($sformatf("bad_stop_word_%0d", k), exp_w, rdata);
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired, the DUT did not finish the tests in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed    = 55664;
    errors  = 0;
    checks  = 0;
    clock   = 1'b0;
    rst_i   = 1'b1;
    uart_rx = 1'b1;
    req     = '0;
    apply_reset();
    test_reset_lockout();
    test_load_and_read();
    test_strobe_merge();
    test_read_backpressure();
    test_after_end_word();
    test_bad_stop_bit();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- boot_loader.f
common/boot_pkg.sv
source/uart_rx.sv
source/boot_ctrl.sv
iccm/iccm_ram.sv
iccm/iccm_axil_slave.sv
source/boot_top.sv
verif/boot_tb.sv

//--- Makefile
# Verilator build and run of the boot loader testbench

TOP       ?= boot_tb
FLIST     ?= boot_loader.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "result: FAIL"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
	  echo "result: FAIL, no verdict in $(LOG)"; exit 1; \
	else \
	  echo "result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
